//--- hdl/ao_periph_pkg.sv
// Address map and register offsets of the always-on window
// Only full-word accesses are decoded; unlisted offsets read zero

`default_nettype none

package ao_periph_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [1:0]  periph_sel_t;
  // Byte offset inside one 4 KB peripheral slot
  typedef logic [11:0] reg_offset_t;

  localparam int unsigned NUM_AO_PERIPH = 4;

  localparam addr_t AO_BASE = 32'h2000_0000;

  localparam periph_sel_t SOC_CTRL_IDX  = 2'd0;
  localparam periph_sel_t FAST_INTR_IDX = 2'd1;
  localparam periph_sel_t GPIO_IDX      = 2'd2;
  localparam periph_sel_t TIMER_IDX     = 2'd3;

  localparam addr_t SOC_CTRL_BASE  = AO_BASE + 32'h0000_0000;
  localparam addr_t FAST_INTR_BASE = AO_BASE + 32'h0000_1000;
  localparam addr_t GPIO_BASE      = AO_BASE + 32'h0000_2000;
  localparam addr_t TIMER_BASE     = AO_BASE + 32'h0000_3000;

  // SoC control
  localparam reg_offset_t SOC_EXIT_VALID = 12'h000;
  localparam reg_offset_t SOC_EXIT_VALUE = 12'h004;
  localparam reg_offset_t SOC_BOOT_SEL   = 12'h008;

  // Fast interrupt controller
  localparam reg_offset_t FI_PENDING = 12'h000;
  localparam reg_offset_t FI_CLEAR   = 12'h004;
  localparam reg_offset_t FI_ENABLE  = 12'h008;

  // GPIO
  localparam reg_offset_t GPIO_IN          = 12'h000;
  localparam reg_offset_t GPIO_OUT         = 12'h004;
  localparam reg_offset_t GPIO_OUT_EN      = 12'h008;
  localparam reg_offset_t GPIO_INTR_EN     = 12'h00C;
  localparam reg_offset_t GPIO_INTR_STATUS = 12'h010;

  // Timer
  localparam reg_offset_t TMR_COUNT   = 12'h000;
  localparam reg_offset_t TMR_COMPARE = 12'h004;
  localparam reg_offset_t TMR_CTRL    = 12'h008;

endpackage

`default_nettype wire

//--- hdl/obi_to_reg_bridge.sv
// OBI slave to register bus; grants in the request cycle when ready
// Response comes one cycle after the grant; writes return zero data

`default_nettype none

module obi_to_reg_bridge (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  input  logic                 obi_req_i,
  input  logic                 obi_we_i,
  input  ao_periph_pkg::addr_t obi_addr_i,
  input  ao_periph_pkg::data_t obi_wdata_i,
  output logic                 obi_gnt_o,
  output logic                 obi_rvalid_o,
  output ao_periph_pkg::data_t obi_rdata_o,

  output logic                 reg_valid_o,
  output logic                 reg_write_o,
  output ao_periph_pkg::addr_t reg_addr_o,
  output ao_periph_pkg::data_t reg_wdata_o,
  input  logic                 reg_ready_i,
  input  ao_periph_pkg::data_t reg_rdata_i
);

  import ao_periph_pkg::*;

  logic  rvalid_q;
  data_t rdata_q;

  // Request fields are stable until grant, so they drive the bus directly
  assign reg_valid_o = obi_req_i;
  assign reg_write_o = obi_we_i;
  assign reg_addr_o  = obi_addr_i;
  assign reg_wdata_o = obi_wdata_i;

  assign obi_gnt_o = obi_req_i & reg_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= obi_gnt_o;
    end
  end

  // Response data, only meaningful together with rvalid
  always_ff @(posedge clk_i) begin
    if (obi_gnt_o) begin
      rdata_q <= obi_we_i ? '0 : reg_rdata_i;
    end
  end

  assign obi_rvalid_o = rvalid_q;
  assign obi_rdata_o  = rdata_q;

  // Master keeps the request and its fields until it sees the grant
  req_held_until_gnt_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (obi_req_i && !obi_gnt_o) |=> (obi_req_i && $stable(obi_we_i) &&
                                   $stable(obi_addr_i) && $stable(obi_wdata_i)));

endmodule

`default_nettype wire

//--- hdl/reg_bus_demux.sv
// Routes a register transfer to one of four 4 KB slots
// Unmapped addresses complete with zero read data

`default_nettype none

module reg_bus_demux (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,

  input  logic                                     in_valid_i,
  input  ao_periph_pkg::addr_t                     in_addr_i,
  output logic                                     in_ready_o,
  output ao_periph_pkg::data_t                     in_rdata_o,

  output logic [ao_periph_pkg::NUM_AO_PERIPH-1:0]  out_valid_o,
  input  ao_periph_pkg::data_t                     out_rdata0_i,
  input  ao_periph_pkg::data_t                     out_rdata1_i,
  input  ao_periph_pkg::data_t                     out_rdata2_i,
  input  ao_periph_pkg::data_t                     out_rdata3_i
);

  import ao_periph_pkg::*;

  logic        mapped;
  periph_sel_t sel;

  assign mapped = (in_addr_i[31:14] == AO_BASE[31:14]);
  assign sel    = in_addr_i[13:12];

  // Every peripheral answers in the cycle it is selected
  assign in_ready_o = 1'b1;

  always_comb begin
    out_valid_o = '0;
    if (in_valid_i && mapped) begin
      out_valid_o[sel] = 1'b1;
    end
  end

  always_comb begin
    in_rdata_o = '0;
    if (mapped) begin
      case (sel)
        2'd0:    in_rdata_o = out_rdata0_i;
        2'd1:    in_rdata_o = out_rdata1_i;
        2'd2:    in_rdata_o = out_rdata2_i;
        default: in_rdata_o = out_rdata3_i;
      endcase
    end
  end

  // Peripherals decode word offsets only
  word_aligned_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    in_valid_i |-> (in_addr_i[1:0] == 2'b00));

endmodule

`default_nettype wire

//--- hdl/soc_ctrl.sv
// Exit status registers for the simulation harness, boot-select readback
// Boot-select is read straight from the pin without synchronization

`default_nettype none

module soc_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  input  logic                       reg_valid_i,
  input  logic                       reg_write_i,
  input  ao_periph_pkg::reg_offset_t reg_offset_i,
  input  ao_periph_pkg::data_t       reg_wdata_i,
  output ao_periph_pkg::data_t       reg_rdata_o,

  input  logic                       boot_select_i,
  output logic                       exit_valid_o,
  output ao_periph_pkg::data_t       exit_value_o
);

  import ao_periph_pkg::*;

  logic  exit_valid_q;
  data_t exit_value_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else if (reg_valid_i && reg_write_i) begin
      case (reg_offset_i)
        SOC_EXIT_VALID: exit_valid_q <= reg_wdata_i[0];
        SOC_EXIT_VALUE: exit_value_q <= reg_wdata_i;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (reg_offset_i)
      SOC_EXIT_VALID: reg_rdata_o = {31'b0, exit_valid_q};
      SOC_EXIT_VALUE: reg_rdata_o = exit_value_q;
      SOC_BOOT_SEL:   reg_rdata_o = {31'b0, boot_select_i};
      default:        reg_rdata_o = '0;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

  // Exit value only moves after a bus write to its own offset
  exit_value_by_write_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$stable(exit_value_o) |-> $past(reg_valid_i && reg_write_i &&
                                     reg_offset_i == SOC_EXIT_VALUE));

endmodule

`default_nettype wire

//--- hdl/fast_intr_ctrl.sv
// Fast interrupt lines are sampled as levels, no synchronizer
// A line held high keeps its pending bit set through a clear

`default_nettype none

module fast_intr_ctrl #(
  parameter int unsigned NumFastIntr = 15
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  input  logic                       reg_valid_i,
  input  logic                       reg_write_i,
  input  ao_periph_pkg::reg_offset_t reg_offset_i,
  input  ao_periph_pkg::data_t       reg_wdata_i,
  output ao_periph_pkg::data_t       reg_rdata_o,

  input  logic [NumFastIntr-1:0]     fast_intr_i,
  output logic [NumFastIntr-1:0]     fast_intr_o
);

  import ao_periph_pkg::*;

  logic                   wr_en;
  logic [NumFastIntr-1:0] pending_q;
  logic [NumFastIntr-1:0] enable_q;
  logic [NumFastIntr-1:0] clear_mask;

  assign wr_en      = reg_valid_i & reg_write_i;
  assign clear_mask = (wr_en && reg_offset_i == FI_CLEAR) ? reg_wdata_i[NumFastIntr-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      // Set wins over clear
      pending_q <= (pending_q & ~clear_mask) | fast_intr_i;
      if (wr_en && reg_offset_i == FI_ENABLE) begin
        enable_q <= reg_wdata_i[NumFastIntr-1:0];
      end
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    case (reg_offset_i)
      FI_PENDING: reg_rdata_o[NumFastIntr-1:0] = pending_q;
      FI_ENABLE:  reg_rdata_o[NumFastIntr-1:0] = enable_q;
      default: ;
    endcase
  end

  assign fast_intr_o = pending_q & enable_q;

endmodule

`default_nettype wire

//--- hdl/gpio_ao.sv
// Inputs cross two flops before use, so pin changes show up late
// Only rising edges raise interrupts; status is write-one-to-clear

`default_nettype none

module gpio_ao #(
  parameter int unsigned NumGpio = 8
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  input  logic                       reg_valid_i,
  input  logic                       reg_write_i,
  input  ao_periph_pkg::reg_offset_t reg_offset_i,
  input  ao_periph_pkg::data_t       reg_wdata_i,
  output ao_periph_pkg::data_t       reg_rdata_o,

  input  logic [NumGpio-1:0]         cio_gpio_i,
  output logic [NumGpio-1:0]         cio_gpio_o,
  output logic [NumGpio-1:0]         cio_gpio_en_o,
  output logic [NumGpio-1:0]         intr_gpio_o
);

  import ao_periph_pkg::*;

  logic               wr_en;
  logic [NumGpio-1:0] wdata;
  logic [NumGpio-1:0] sync_q1;
  logic [NumGpio-1:0] sync_q2;
  logic [NumGpio-1:0] prev_q;
  logic [NumGpio-1:0] out_q;
  logic [NumGpio-1:0] out_en_q;
  logic [NumGpio-1:0] intr_en_q;
  logic [NumGpio-1:0] status_q;
  logic [NumGpio-1:0] rise;
  logic [NumGpio-1:0] status_clr;

  assign wr_en      = reg_valid_i & reg_write_i;
  assign wdata      = reg_wdata_i[NumGpio-1:0];
  assign rise       = sync_q2 & ~prev_q & intr_en_q;
  assign status_clr = (wr_en && reg_offset_i == GPIO_INTR_STATUS) ? wdata : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q1   <= '0;
      sync_q2   <= '0;
      prev_q    <= '0;
      out_q     <= '0;
      out_en_q  <= '0;
      intr_en_q <= '0;
      status_q  <= '0;
    end else begin
      sync_q1  <= cio_gpio_i;
      sync_q2  <= sync_q1;
      prev_q   <= sync_q2;
      status_q <= (status_q & ~status_clr) | rise;
      if (wr_en) begin
        case (reg_offset_i)
          GPIO_OUT:     out_q     <= wdata;
          GPIO_OUT_EN:  out_en_q  <= wdata;
          GPIO_INTR_EN: intr_en_q <= wdata;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    case (reg_offset_i)
      GPIO_IN:          reg_rdata_o[NumGpio-1:0] = sync_q2;
      GPIO_OUT:         reg_rdata_o[NumGpio-1:0] = out_q;
      GPIO_OUT_EN:      reg_rdata_o[NumGpio-1:0] = out_en_q;
      GPIO_INTR_EN:     reg_rdata_o[NumGpio-1:0] = intr_en_q;
      GPIO_INTR_STATUS: reg_rdata_o[NumGpio-1:0] = status_q;
      default: ;
    endcase
  end

  assign cio_gpio_o    = out_q;
  assign cio_gpio_en_o = out_en_q;
  assign intr_gpio_o   = status_q;

endmodule

`default_nettype wire

//--- hdl/ao_timer.sv
// 32-bit counter that wraps silently; interrupt is a level, not a pulse
// A COUNT write takes priority over the increment in the same cycle

`default_nettype none

module ao_timer (
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  input  logic                       reg_valid_i,
  input  logic                       reg_write_i,
  input  ao_periph_pkg::reg_offset_t reg_offset_i,
  input  ao_periph_pkg::data_t       reg_wdata_i,
  output ao_periph_pkg::data_t       reg_rdata_o,

  output logic                       timer_intr_o
);

  import ao_periph_pkg::*;

  logic  wr_en;
  logic  enable_q;
  data_t count_q;
  data_t compare_q;

  assign wr_en = reg_valid_i & reg_write_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      enable_q  <= 1'b0;
      count_q   <= '0;
      compare_q <= '0;
    end else begin
      if (wr_en && reg_offset_i == TMR_COUNT) begin
        count_q <= reg_wdata_i;
      end else if (enable_q) begin
        count_q <= count_q + 32'd1;
      end
      if (wr_en && reg_offset_i == TMR_COMPARE) begin
        compare_q <= reg_wdata_i;
      end
      if (wr_en && reg_offset_i == TMR_CTRL) begin
        enable_q <= reg_wdata_i[0];
      end
    end
  end

  always_comb begin
    case (reg_offset_i)
      TMR_COUNT:   reg_rdata_o = count_q;
      TMR_COMPARE: reg_rdata_o = compare_q;
      TMR_CTRL:    reg_rdata_o = {31'b0, enable_q};
      default:     reg_rdata_o = '0;
    endcase
  end

  assign timer_intr_o = enable_q && (count_q >= compare_q);

endmodule

`default_nettype wire

//--- hdl/ao_peripheral_subsystem.sv
// Always-on peripherals behind one OBI slave port, full-word accesses only
// NumGpio and NumFastIntr must not exceed 32

`default_nettype none

module ao_peripheral_subsystem #(
  parameter int unsigned NumGpio     = 8,
  parameter int unsigned NumFastIntr = 15
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  // OBI slave
  input  logic                   slave_req_i,
  input  logic                   slave_we_i,
  input  ao_periph_pkg::addr_t   slave_addr_i,
  input  ao_periph_pkg::data_t   slave_wdata_i,
  output logic                   slave_gnt_o,
  output logic                   slave_rvalid_o,
  output ao_periph_pkg::data_t   slave_rdata_o,

  input  logic                   boot_select_i,
  output logic                   exit_valid_o,
  output ao_periph_pkg::data_t   exit_value_o,

  input  logic [NumFastIntr-1:0] fast_intr_i,
  output logic [NumFastIntr-1:0] fast_intr_o,

  input  logic [NumGpio-1:0]     cio_gpio_i,
  output logic [NumGpio-1:0]     cio_gpio_o,
  output logic [NumGpio-1:0]     cio_gpio_en_o,
  output logic [NumGpio-1:0]     intr_gpio_o,

  output logic                   timer_intr_o
);

  import ao_periph_pkg::*;

  logic                     reg_valid;
  logic                     reg_write;
  logic                     reg_ready;
  addr_t                    reg_addr;
  data_t                    reg_wdata;
  data_t                    reg_rdata;
  reg_offset_t              reg_offset;
  logic [NUM_AO_PERIPH-1:0] periph_valid;
  data_t                    soc_ctrl_rdata;
  data_t                    fast_intr_rdata;
  data_t                    gpio_rdata;
  data_t                    timer_rdata;

  assign reg_offset = reg_addr[11:0];

  obi_to_reg_bridge u_bridge (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .obi_req_i    (slave_req_i),
    .obi_we_i     (slave_we_i),
    .obi_addr_i   (slave_addr_i),
    .obi_wdata_i  (slave_wdata_i),
    .obi_gnt_o    (slave_gnt_o),
    .obi_rvalid_o (slave_rvalid_o),
    .obi_rdata_o  (slave_rdata_o),
    .reg_valid_o  (reg_valid),
    .reg_write_o  (reg_write),
    .reg_addr_o   (reg_addr),
    .reg_wdata_o  (reg_wdata),
    .reg_ready_i  (reg_ready),
    .reg_rdata_i  (reg_rdata)
  );

  // Read data ports follow the slot index order
  reg_bus_demux u_demux (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .in_valid_i   (reg_valid),
    .in_addr_i    (reg_addr),
    .in_ready_o   (reg_ready),
    .in_rdata_o   (reg_rdata),
    .out_valid_o  (periph_valid),
    .out_rdata0_i (soc_ctrl_rdata),
    .out_rdata1_i (fast_intr_rdata),
    .out_rdata2_i (gpio_rdata),
    .out_rdata3_i (timer_rdata)
  );

  soc_ctrl u_soc_ctrl (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .reg_valid_i   (periph_valid[SOC_CTRL_IDX]),
    .reg_write_i   (reg_write),
    .reg_offset_i  (reg_offset),
    .reg_wdata_i   (reg_wdata),
    .reg_rdata_o   (soc_ctrl_rdata),
    .boot_select_i (boot_select_i),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o)
  );

  fast_intr_ctrl #(
    .NumFastIntr (NumFastIntr)
  ) u_fast_intr_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .reg_valid_i  (periph_valid[FAST_INTR_IDX]),
    .reg_write_i  (reg_write),
    .reg_offset_i (reg_offset),
    .reg_wdata_i  (reg_wdata),
    .reg_rdata_o  (fast_intr_rdata),
    .fast_intr_i  (fast_intr_i),
    .fast_intr_o  (fast_intr_o)
  );

  gpio_ao #(
    .NumGpio (NumGpio)
  ) u_gpio_ao (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .reg_valid_i   (periph_valid[GPIO_IDX]),
    .reg_write_i   (reg_write),
    .reg_offset_i  (reg_offset),
    .reg_wdata_i   (reg_wdata),
    .reg_rdata_o   (gpio_rdata),
    .cio_gpio_i    (cio_gpio_i),
    .cio_gpio_o    (cio_gpio_o),
    .cio_gpio_en_o (cio_gpio_en_o),
    .intr_gpio_o   (intr_gpio_o)
  );

  ao_timer u_ao_timer (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .reg_valid_i  (periph_valid[TIMER_IDX]),
    .reg_write_i  (reg_write),
    .reg_offset_i (reg_offset),
    .reg_wdata_i  (reg_wdata),
    .reg_rdata_o  (timer_rdata),
    .timer_intr_o (timer_intr_o)
  );

endmodule

`default_nettype wire

//--- test/tb_ao_peripheral_subsystem.sv
// Testbench for the always-on subsystem; DUT uses default NumGpio and NumFastIntr
// Bus tasks are called right after a rising edge and return on the rvalid edge

`default_nettype none

module tb_ao_peripheral_subsystem;

  import ao_periph_pkg::*;

  localparam int unsigned NUM_GPIO   = 8;
  localparam int unsigned NUM_FI     = 15;
  // About 80 accesses of 3 cycles plus timer and GPIO waits stay far below this
  localparam int unsigned MAX_CYCLES = 3000;

  logic                clk;
  logic                rst_n;
  logic                req;
  logic                we;
  addr_t               addr;
  data_t               wdata;
  logic                gnt;
  logic                rvalid;
  data_t               rdata;
  logic                boot_select;
  logic                exit_valid;
  data_t               exit_value;
  logic [NUM_FI-1:0]   fast_intr_in;
  logic [NUM_FI-1:0]   fast_intr_out;
  logic [NUM_GPIO-1:0] gpio_in;
  logic [NUM_GPIO-1:0] gpio_out;
  logic [NUM_GPIO-1:0] gpio_out_en;
  logic [NUM_GPIO-1:0] gpio_intr;
  logic                timer_intr;
  int unsigned         cycle_count = 0;

  // Reference model of the register contents
  logic                m_exit_valid = 1'b0;
  data_t               m_exit_value = '0;
  logic [NUM_FI-1:0]   m_fi_pending = '0;
  logic [NUM_FI-1:0]   m_fi_enable = '0;
  logic [NUM_GPIO-1:0] m_gpio_in = '0;
  logic [NUM_GPIO-1:0] m_gpio_out = '0;
  logic [NUM_GPIO-1:0] m_gpio_out_en = '0;
  logic [NUM_GPIO-1:0] m_gpio_intr_en = '0;
  logic [NUM_GPIO-1:0] m_gpio_status = '0;
  data_t               m_tmr_count = '0;
  data_t               m_tmr_compare = '0;
  logic                m_tmr_ctrl = 1'b0;

  ao_peripheral_subsystem dut0 (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .slave_req_i    (req),
    .slave_we_i     (we),
    .slave_addr_i   (addr),
    .slave_wdata_i  (wdata),
    .slave_gnt_o    (gnt),
    .slave_rvalid_o (rvalid),
    .slave_rdata_o  (rdata),
    .boot_select_i  (boot_select),
    .exit_valid_o   (exit_valid),
    .exit_value_o   (exit_value),
    .fast_intr_i    (fast_intr_in),
    .fast_intr_o    (fast_intr_out),
    .cio_gpio_i     (gpio_in),
    .cio_gpio_o     (gpio_out),
    .cio_gpio_en_o  (gpio_out_en),
    .intr_gpio_o    (gpio_intr),
    .timer_intr_o   (timer_intr)
  );

  always #5 clk = ~clk;

  task automatic stop_with_failure();
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic expect_equal(input string name, input data_t got, input data_t exp);
    assert (got === exp) else begin
      $display("error: %s expected 0x%08h got 0x%08h", name, exp, got);
      stop_with_failure();
    end
  endtask

  task automatic bus_access(input logic write, input addr_t a, input data_t d,
                            output data_t rd);
    req   <= 1'b1;
    we    <= write;
    addr  <= a;
    wdata <= d;
    do @(posedge clk); while (!gnt);
    req <= 1'b0;
    we  <= 1'b0;
    do @(posedge clk); while (!rvalid);
    rd = rdata;
  endtask

  task automatic write_reg(input addr_t a, input data_t d);
    data_t unused;
    bus_access(1'b1, a, d, unused);
  endtask

  task automatic read_and_compare(input addr_t a, input data_t exp);
    data_t rd;
    bus_access(1'b0, a, '0, rd);
    expect_equal($sformatf("slave_rdata_o at 0x%08h", a), rd, exp);
  endtask

  // boot_select_i is held low whenever this runs
  task automatic verify_register_file();
    read_and_compare(SOC_CTRL_BASE + SOC_EXIT_VALID, 32'(m_exit_valid));
    read_and_compare(SOC_CTRL_BASE + SOC_EXIT_VALUE, m_exit_value);
    read_and_compare(SOC_CTRL_BASE + SOC_BOOT_SEL, '0);
    read_and_compare(FAST_INTR_BASE + FI_PENDING, 32'(m_fi_pending));
    read_and_compare(FAST_INTR_BASE + FI_ENABLE, 32'(m_fi_enable));
    read_and_compare(GPIO_BASE + GPIO_IN, 32'(m_gpio_in));
    read_and_compare(GPIO_BASE + GPIO_OUT, 32'(m_gpio_out));
    read_and_compare(GPIO_BASE + GPIO_OUT_EN, 32'(m_gpio_out_en));
    read_and_compare(GPIO_BASE + GPIO_INTR_EN, 32'(m_gpio_intr_en));
    read_and_compare(GPIO_BASE + GPIO_INTR_STATUS, 32'(m_gpio_status));
    read_and_compare(TIMER_BASE + TMR_COUNT, m_tmr_count);
    read_and_compare(TIMER_BASE + TMR_COMPARE, m_tmr_compare);
    read_and_compare(TIMER_BASE + TMR_CTRL, 32'(m_tmr_ctrl));
  endtask

  gnt_same_cycle_a: assert property (@(posedge clk) disable iff (!rst_n)
    req |-> gnt)
    else begin
      $display("request was not granted in its own cycle");
      stop_with_failure();
    end

  rvalid_after_gnt_a: assert property (@(posedge clk) disable iff (!rst_n)
    gnt |=> rvalid)
    else begin
      $display("rvalid missing one cycle after the grant");
      stop_with_failure();
    end

  rvalid_needs_gnt_a: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid |-> $past(gnt))
    else begin
      $display("rvalid without a grant in the cycle before");
      stop_with_failure();
    end

  reset_values_a: assert property (@(posedge clk)
    $rose(rst_n) |-> (!gnt && !rvalid && !exit_valid && exit_value == '0 &&
                      fast_intr_out == '0 && gpio_out == '0 && gpio_out_en == '0 &&
                      gpio_intr == '0 && !timer_intr))
    else begin
      $display("outputs were not all zero when reset was released");
      stop_with_failure();
    end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: test did not finish within %0d cycles", MAX_CYCLES);
      stop_with_failure();
    end
  end

  initial begin
    data_t               rnd;
    data_t               cmp;
    int unsigned         j;
    logic [NUM_FI-1:0]   fi_clr;
    logic [NUM_GPIO-1:0] clr_bit;
    addr_t               bad_addr [9];

    rnd          = $urandom(88);
    clk          = 1'b0;
    rst_n        = 1'b0;
    req          = 1'b0;
    we           = 1'b0;
    addr         = '0;
    wdata        = '0;
    boot_select  = 1'b0;
    fast_intr_in = '0;
    gpio_in      = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // SoC control
    for (j = 0; j < 4; j++) begin
      m_exit_value = $urandom;
      write_reg(SOC_CTRL_BASE + SOC_EXIT_VALUE, m_exit_value);
      expect_equal("exit_value_o", exit_value, m_exit_value);
      read_and_compare(SOC_CTRL_BASE + SOC_EXIT_VALUE, m_exit_value);
    end
    m_exit_valid = 1'b1;
    write_reg(SOC_CTRL_BASE + SOC_EXIT_VALID, 32'd1);
    expect_equal("exit_valid_o", 32'(exit_valid), 32'd1);
    read_and_compare(SOC_CTRL_BASE + SOC_EXIT_VALID, 32'd1);
    boot_select <= 1'b1;
    @(posedge clk);
    read_and_compare(SOC_CTRL_BASE + SOC_BOOT_SEL, 32'd1);
    boot_select <= 1'b0;
    @(posedge clk);
    read_and_compare(SOC_CTRL_BASE + SOC_BOOT_SEL, 32'd0);

    // Fast interrupts, two one-cycle pulses
    for (j = 0; j < 2; j++) begin
      rnd = $urandom;
      fast_intr_in <= rnd[NUM_FI-1:0];
      m_fi_pending = m_fi_pending | rnd[NUM_FI-1:0];
      @(posedge clk);
      fast_intr_in <= '0;
      @(posedge clk);
    end
    read_and_compare(FAST_INTR_BASE + FI_PENDING, 32'(m_fi_pending));
    rnd = $urandom;
    m_fi_enable = rnd[NUM_FI-1:0];
    write_reg(FAST_INTR_BASE + FI_ENABLE, rnd);
    expect_equal("fast_intr_o", 32'(fast_intr_out), 32'(m_fi_pending & m_fi_enable));
    read_and_compare(FAST_INTR_BASE + FI_ENABLE, 32'(m_fi_enable));
    rnd = $urandom;
    fi_clr = rnd[NUM_FI-1:0];
    m_fi_pending = m_fi_pending & ~fi_clr;
    write_reg(FAST_INTR_BASE + FI_CLEAR, 32'(fi_clr));
    expect_equal("fast_intr_o", 32'(fast_intr_out), 32'(m_fi_pending & m_fi_enable));
    read_and_compare(FAST_INTR_BASE + FI_PENDING, 32'(m_fi_pending));

    // GPIO outputs
    rnd = $urandom;
    m_gpio_out = rnd[NUM_GPIO-1:0];
    write_reg(GPIO_BASE + GPIO_OUT, 32'(m_gpio_out));
    expect_equal("cio_gpio_o", 32'(gpio_out), 32'(m_gpio_out));
    rnd = $urandom;
    m_gpio_out_en = rnd[NUM_GPIO-1:0];
    write_reg(GPIO_BASE + GPIO_OUT_EN, 32'(m_gpio_out_en));
    expect_equal("cio_gpio_en_o", 32'(gpio_out_en), 32'(m_gpio_out_en));

    // GPIO edge interrupts, mask leaves at least one pin enabled and one disabled
    m_gpio_intr_en = NUM_GPIO'($urandom_range(254, 1));
    write_reg(GPIO_BASE + GPIO_INTR_EN, 32'(m_gpio_intr_en));
    gpio_in <= '1;
    m_gpio_in = '1;
    for (j = 0; j < 4; j++) begin
      @(posedge clk);
      if (gpio_intr == m_gpio_intr_en) break;
    end
    expect_equal("intr_gpio_o", 32'(gpio_intr), 32'(m_gpio_intr_en));
    repeat (6) begin
      @(posedge clk);
      expect_equal("intr_gpio_o", 32'(gpio_intr), 32'(m_gpio_intr_en));
    end
    m_gpio_status = m_gpio_intr_en;
    read_and_compare(GPIO_BASE + GPIO_IN, 32'(m_gpio_in));
    clr_bit = m_gpio_status & (~m_gpio_status + 1'b1);
    m_gpio_status = m_gpio_status & ~clr_bit;
    write_reg(GPIO_BASE + GPIO_INTR_STATUS, 32'(clr_bit));
    expect_equal("intr_gpio_o", 32'(gpio_intr), 32'(m_gpio_status));
    read_and_compare(GPIO_BASE + GPIO_INTR_STATUS, 32'(m_gpio_status));
    // Only falling edges from here on
    rnd = $urandom;
    gpio_in <= rnd[NUM_GPIO-1:0];
    m_gpio_in = rnd[NUM_GPIO-1:0];
    repeat (3) @(posedge clk);
    read_and_compare(GPIO_BASE + GPIO_IN, 32'(m_gpio_in));
    expect_equal("intr_gpio_o", 32'(gpio_intr), 32'(m_gpio_status));

    // Timer, the count seen at the j-th edge after the enable grant is j-1
    cmp = $urandom_range(20, 5);
    write_reg(TIMER_BASE + TMR_COUNT, '0);
    write_reg(TIMER_BASE + TMR_COMPARE, cmp);
    write_reg(TIMER_BASE + TMR_CTRL, 32'd1);
    for (j = 1; j <= cmp + 4; j++) begin
      if (j > 1) @(posedge clk);
      expect_equal("timer_intr_o", 32'(timer_intr), (j - 1 >= cmp) ? 32'd1 : 32'd0);
    end
    write_reg(TIMER_BASE + TMR_CTRL, 32'd0);
    expect_equal("timer_intr_o", 32'(timer_intr), 32'd0);
    m_tmr_compare = cmp;
    m_tmr_count = $urandom;
    write_reg(TIMER_BASE + TMR_COUNT, m_tmr_count);
    verify_register_file();

    // Unmapped windows and unknown offsets, several alias real registers
    bad_addr = '{32'h1000_0004, 32'h2000_4004, 32'h3000_3008,
                 SOC_CTRL_BASE + 32'h00C, FAST_INTR_BASE + 32'h00C,
                 GPIO_BASE + 32'h014, TIMER_BASE + 32'h00C,
                 GPIO_BASE + 32'hFFC, 32'hA000_0000};
    foreach (bad_addr[i]) begin
      read_and_compare(bad_addr[i], '0);
      rnd = $urandom;
      write_reg(bad_addr[i], rnd);
    end
    verify_register_file();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
hdl/ao_periph_pkg.sv
hdl/obi_to_reg_bridge.sv
hdl/reg_bus_demux.sv
hdl/soc_ctrl.sv
hdl/fast_intr_ctrl.sv
hdl/gpio_ao.sv
hdl/ao_timer.sv
hdl/ao_peripheral_subsystem.sv
test/tb_ao_peripheral_subsystem.sv

//--- Bender.yml
package:
  name: ao_peripheral_subsystem

sources:
  - hdl/ao_periph_pkg.sv
  - hdl/obi_to_reg_bridge.sv
  - hdl/reg_bus_demux.sv
  - hdl/soc_ctrl.sv
  - hdl/fast_intr_ctrl.sv
  - hdl/gpio_ao.sv
  - hdl/ao_timer.sv
  - hdl/ao_peripheral_subsystem.sv
  - target: test
    files:
      - test/tb_ao_peripheral_subsystem.sv
